/* rtl/icache_pkg.sv */
package icache_pkg;

	// ##################################################
	// Widths.
	// ##################################################

	localparam int addr_w = 32;	// Fetch address.
	localparam int data_w = 32;	// Instruction word.
	localparam int tag_w = 8;	// Requester toggle tag.

	// Word aligned fetches, index starts above the byte offset.
	localparam int byte_lsb = 2;

	// ##################################################
	// Line store entry.
	// ##################################################

	// Full address kept per line, so a hit is an exact match.
	// No separate tag field.
	typedef struct packed {
		logic [addr_w-1:0] addr;	// Address the word came from.
		logic [data_w-1:0] data;	// Instruction word.
	} line_entry_t;	// 64 bits.

	// ##################################################
	// Memory bus request.
	// ##################################################

	// Four-phase handshake, request side only.
	// Ack and read data come back on plain wires.
	typedef struct packed {
		logic req;	// Held high until ack is seen.
		logic [addr_w-1:0] addr;	// Word address to fetch.
	} bus_req_t;	// 33 bits.

endpackage

/* rtl/icache_bram.sv */
module icache_bram #(
	parameter int LINES = 128
) (
	input  logic                    i_clock,
	input  logic                    i_we,
	input  logic [$clog2(LINES)-1:0] i_index,
	input  icache_pkg::line_entry_t i_wentry,
	output icache_pkg::line_entry_t o_rentry
);

	// ##################################################
	// Storage.
	// ##################################################

	// One entry per cache line.
	icache_pkg::line_entry_t mem [LINES];

	// Write port.
	// Lands on the edge that samples i_we.
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_index] <= i_wentry;	// Address plus word.
		end
	end

	// ##################################################
	// Read port.
	// ##################################################

	// Registered read, every cycle.
	// Entry shows up one cycle after the index.
	// A write to the same index returns the old entry here,
	// the controller never reads back a line it is writing.
	always_ff @(posedge i_clock) begin
		o_rentry <= mem[i_index];
	end

	// Block RAM style, no enable on the read side.
	// The controller only trusts o_rentry in its compare state.

endmodule

/* rtl/icache_ctrl.sv */
module icache_ctrl #(
	parameter int LINES = 128
) (
	input  logic                             i_clock,
	input  logic                             i_rst_n,
	input  logic [icache_pkg::tag_w-1:0]     i_req_tag,
	input  logic [icache_pkg::addr_w-1:0]    i_address,
	input  logic                             i_flush,
	output logic [icache_pkg::tag_w-1:0]     o_resp_tag,
	output logic [icache_pkg::data_w-1:0]    o_rdata,
	output icache_pkg::bus_req_t             o_bus,
	input  logic [icache_pkg::data_w-1:0]    i_bus_rdata,
	input  logic                             i_bus_ack
);

	localparam int IDX_W = $clog2(LINES);	// Line index width.

	typedef enum logic [1:0] {
		ST_IDLE,	// Waiting for a tag change.
		ST_COMPARE,	// Line store read, then address match.
		ST_FILL,	// Bus handshake running.
		ST_WRITE	// Line write, valid set.
	} state_t;

	state_t state_q;
	logic cmp_wait_q;	// Entry not back from the line store yet.
	logic [LINES-1:0] valid_q;	// One bit per line.
	logic bus_req_q;
	logic [icache_pkg::addr_w-1:0] bus_addr_q;
	logic we_q;
	logic [IDX_W-1:0] index_q;
	icache_pkg::line_entry_t wentry_q;
	icache_pkg::line_entry_t rentry;

	logic req_new;	// Tags differ, request pending.
	logic start_lookup;
	logic cmp_ready;
	logic hit;
	logic cmp_hit;
	logic cmp_miss;
	logic fill_done;

	// ##################################################
	// Line store.
	// ##################################################

	icache_bram #(
		.LINES(LINES)
	) u_bram (
		.i_clock (i_clock),
		.i_we    (we_q),
		.i_index (index_q),
		.i_wentry(wentry_q),
		.o_rentry(rentry)
	);

	// ##################################################
	// Decode.
	// ##################################################

	assign req_new = (i_req_tag != o_resp_tag);
	// Wait for the memory to drop ack from the last fill.
	assign start_lookup = (state_q == ST_IDLE) && req_new && !i_bus_ack;
	assign cmp_ready = (state_q == ST_COMPARE) && !cmp_wait_q;	// Entry valid now.

	// Exact address match, conflicts on the same index miss.
	assign hit = valid_q[index_q] && (rentry.addr == i_address);
	assign cmp_hit = cmp_ready && hit;
	assign cmp_miss = cmp_ready && !hit;
	assign fill_done = (state_q == ST_FILL) && i_bus_ack;	// Data valid with ack.

	assign o_bus = '{req: bus_req_q, addr: bus_addr_q};

	// ##################################################
	// Control FSM.
	// ##################################################

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= ST_IDLE;
			cmp_wait_q <= 1'b0;
			valid_q <= '0;	// Cache starts empty.
			bus_req_q <= 1'b0;
			we_q <= 1'b0;
			o_resp_tag <= '0;	// Matches idle requester.
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_flush) begin
						valid_q <= '0;	// Drop every line.
					end
					if (start_lookup) begin
						cmp_wait_q <= 1'b1;	// One cycle for the read.
						state_q <= ST_COMPARE;
					end
				end

				ST_COMPARE: begin
					cmp_wait_q <= 1'b0;
					if (cmp_hit) begin
						o_resp_tag <= i_req_tag;	// Done, two cycles after detect.
						state_q <= ST_IDLE;
					end else if (cmp_miss) begin
						bus_req_q <= 1'b1;	// Ack already low from idle.
						state_q <= ST_FILL;
					end
				end

				ST_FILL: begin
					// No timeout, memory sets the pace.
					if (fill_done) begin
						bus_req_q <= 1'b0;
						o_resp_tag <= i_req_tag;	// Answer with bus data.
						we_q <= 1'b1;
						state_q <= ST_WRITE;
					end
				end

				ST_WRITE: begin
					we_q <= 1'b0;	// Line written this edge.
					valid_q[index_q] <= 1'b1;
					state_q <= ST_IDLE;
				end

				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ##################################################
	// Datapath registers.
	// ##################################################

	always_ff @(posedge i_clock) begin
		if (start_lookup) begin
			index_q <= i_address[icache_pkg::byte_lsb +: IDX_W];
		end
		if (cmp_hit) begin
			o_rdata <= rentry.data;
		end
		if (cmp_miss) begin
			bus_addr_q <= i_address;
		end
		if (fill_done) begin
			o_rdata <= i_bus_rdata;
			wentry_q <= '{addr: i_address, data: i_bus_rdata};	// Stored next edge.
		end
	end

	// ##################################################
	// Checks.
	// ##################################################

	// Four-phase rule, no new request until ack has dropped.
	a_req_after_ack: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(!o_bus.req && i_bus_ack) |=> !o_bus.req)
		else $error("bus request raised while ack still high");

	// Response tag only ever echoes the request tag.
	a_tag_echo: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_resp_tag != $past(o_resp_tag)) |-> (o_resp_tag == $past(i_req_tag)))
		else $error("response tag changed to a value never requested");

	// Flush only between requests.
	a_flush_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_flush |-> (state_q == ST_IDLE && !req_new))
		else $error("flush arrived with a request pending");

endmodule

/* rtl/icache_top.sv */
module icache_top #(
	parameter int LINES = 128
) (
	input  logic                          i_clock,
	input  logic                          i_rst_n,

	// Requester, toggle tag handshake.
	input  logic [icache_pkg::tag_w-1:0]  i_req_tag,
	input  logic [icache_pkg::addr_w-1:0] i_address,
	input  logic                          i_flush,
	output logic [icache_pkg::tag_w-1:0]  o_resp_tag,
	output logic [icache_pkg::data_w-1:0] o_rdata,

	// Memory bus, four-phase req/ack.
	output logic                          o_bus_req,
	output logic [icache_pkg::addr_w-1:0] o_bus_addr,
	input  logic [icache_pkg::data_w-1:0] i_bus_rdata,
	input  logic                          i_bus_ack
);

	icache_pkg::bus_req_t bus;	// Request from the controller.

	// ##################################################
	// Controller, owns the line store.
	// ##################################################

	icache_ctrl #(
		.LINES(LINES)
	) u_ctrl (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_req_tag  (i_req_tag),
		.i_address  (i_address),
		.i_flush    (i_flush),
		.o_resp_tag (o_resp_tag),
		.o_rdata    (o_rdata),
		.o_bus      (bus),
		.i_bus_rdata(i_bus_rdata),
		.i_bus_ack  (i_bus_ack)
	);

	// Plain wires for the memory side.
	assign o_bus_req = bus.req;
	assign o_bus_addr = bus.addr;	// Full word address.

endmodule

/* verif/icache_mem_model.sv */
module icache_mem_model #(
	parameter logic [icache_pkg::data_w-1:0] DATA_XOR = 32'hc0de_0000
) (
	input  logic                          i_clock,
	input  logic                          i_rst_n,
	input  logic                          i_bus_req,
	input  logic [icache_pkg::addr_w-1:0] i_bus_addr,
	output logic [icache_pkg::data_w-1:0] o_bus_rdata,
	output logic                          o_bus_ack
);

	// ##################################################
	// State.
	// ##################################################

	int seed = 32'hfa97;	// Fixed, runs repeat.
	int wait_cnt;	// Cycles left before ack.
	int fetch_count;	// Read by the testbench.
	logic busy;	// Request seen, ack not yet raised.

	// ##################################################
	// Four-phase responder.
	// ##################################################

	// Runs on the falling edge.
	// Ack and data are stable long before the DUT samples them.
	always @(negedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_ack <= 1'b0;
			o_bus_rdata <= '0;
			wait_cnt <= 0;
			busy <= 1'b0;
			fetch_count <= 0;
		end else if (o_bus_ack) begin
			// Phase four, ack follows req down.
			if (!i_bus_req) begin
				o_bus_ack <= 1'b0;
			end
		end else if (i_bus_req && !busy) begin
			busy <= 1'b1;
			wait_cnt <= 1 + ($unsigned($random(seed)) % 4);	// 1 to 4 cycles.
		end else if (busy) begin
			if (wait_cnt == 1) begin
				o_bus_rdata <= i_bus_addr ^ DATA_XOR;	// Word from the address.
				o_bus_ack <= 1'b1;
				fetch_count <= fetch_count + 1;	// One per bus read.
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	// Address is held with req, so it is only read on the ack edge.

endmodule

/* verif/icache_tb.sv */
module icache_tb;

	localparam int CLK_PERIOD = 10;
	localparam int MAX_OPS = 64;	// Golden lines the array can hold.
	localparam int RESP_LIMIT = 40;	// Cycles a single fetch may take.
	localparam int CYCLES_PER_OP = 20;
	localparam int MARGIN_CYCLES = 100;	// Reset and slack.
	localparam logic [31:0] DATA_XOR = 32'hc0de_0000;
	localparam logic [31:0] OP_FETCH = 32'h1;
	localparam logic [31:0] OP_FLUSH = 32'h2;

	logic clock;
	logic rst_n;
	logic [icache_pkg::tag_w-1:0] req_tag;
	logic [icache_pkg::addr_w-1:0] address;
	logic flush;
	logic [icache_pkg::tag_w-1:0] resp_tag;
	logic [icache_pkg::data_w-1:0] rdata;
	logic bus_req;
	logic [icache_pkg::addr_w-1:0] bus_addr;
	logic [icache_pkg::data_w-1:0] bus_rdata;
	logic bus_ack;

	logic [31:0] golden [4*MAX_OPS];	// Op, address, data, count.
	int n_ops;
	bit ops_loaded;
	int error_count;
	int pass_tests;
	int fail_tests;
	logic [icache_pkg::tag_w-1:0] tag_next;	// Last tag sent.

	// ##################################################
	// DUT and bus memory.
	// ##################################################

	icache_top #(
		.LINES(8)	// Small, conflicts come easy.
	) dut0 (
		.i_clock    (clock),
		.i_rst_n    (rst_n),
		.i_req_tag  (req_tag),
		.i_address  (address),
		.i_flush    (flush),
		.o_resp_tag (resp_tag),
		.o_rdata    (rdata),
		.o_bus_req  (bus_req),
		.o_bus_addr (bus_addr),
		.i_bus_rdata(bus_rdata),
		.i_bus_ack  (bus_ack)
	);

	icache_mem_model #(
		.DATA_XOR(DATA_XOR)
	) mem0 (
		.i_clock    (clock),
		.i_rst_n    (rst_n),
		.i_bus_req  (bus_req),
		.i_bus_addr (bus_addr),
		.o_bus_rdata(bus_rdata),
		.o_bus_ack  (bus_ack)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ##################################################
	// Helpers.
	// ##################################################

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED time %0t: %s = %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_reset_state();
		check_value("o_resp_tag", {24'h0, resp_tag}, 32'h0);
		check_value("o_bus_req", {31'h0, bus_req}, 32'h0);
	endtask

	// Called on a falling edge. New tag, then wait for the echo to move.
	task automatic fetch_word(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic [31:0] exp_count);
		int waited;
		bit responded;
		logic [icache_pkg::tag_w-1:0] old_tag;
		old_tag = resp_tag;	// Echo before this request.
		tag_next = tag_next + 8'd1;	// Never equal to the current echo.
		address = addr;
		req_tag = tag_next;
		waited = 0;
		responded = 1'b0;
		while (!responded && waited < RESP_LIMIT) begin
			@(negedge clock);
			waited++;
			if (bus_req) begin
				check_value("o_bus_addr", bus_addr, addr);	// Miss fetches this word.
			end
			if (resp_tag != old_tag) begin
				responded = 1'b1;
			end
		end
		if (responded) begin
			check_value("o_rdata", rdata, exp_data);
			check_value("o_resp_tag", {24'h0, resp_tag}, {24'h0, tag_next});
			check_value("fetch_count", mem0.fetch_count, exp_count);	// Misses so far.
		end else begin
			$display("fetch of address %h got no response within %0d cycles",
				addr, RESP_LIMIT);
			error_count++;
		end
	endtask

	// Idle gap first, a miss may still be writing its line.
	task automatic pulse_flush(input logic [31:0] exp_count);
		repeat (2) @(negedge clock);
		flush = 1'b1;
		@(negedge clock);
		flush = 1'b0;	// Single cycle.
		@(negedge clock);
		check_value("fetch_count", mem0.fetch_count, exp_count);
	endtask

	// ##################################################
	// Watchdog.
	// ##################################################

	initial begin : watchdog
		int limit_cycles;
		wait (ops_loaded);
		limit_cycles = n_ops * CYCLES_PER_OP + MARGIN_CYCLES;
		#(limit_cycles * CLK_PERIOD);
		$display("run timed out after %0d cycles without finishing", limit_cycles);
		$display(">>> FAIL");
		$finish;
	end

	// ##################################################
	// Stimulus.
	// ##################################################

	initial begin : stimulus
		int i;
		int errors_before;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] count;
		string op_name;
		rst_n = 1'b0;
		req_tag = '0;	// Same as the reset echo, no request.
		address = '0;
		flush = 1'b0;
		tag_next = '0;
		error_count = 0;
		pass_tests = 0;
		fail_tests = 0;
		$readmemh("verif/icache_golden.txt", golden);
		n_ops = 0;
		while (n_ops < MAX_OPS && golden[4*n_ops] != 32'h0) begin
			n_ops++;	// Zero op ends the list.
		end
		if (n_ops == 0) begin
			$display("golden file holds no operations");
			error_count++;
		end
		ops_loaded = 1'b1;
		repeat (3) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		errors_before = error_count;
		check_reset_state();	// Before any request.
		if (error_count == errors_before) begin
			pass_tests++;
			$display("test 0 reset state: pass");
		end else begin
			fail_tests++;
			$display("test 0 reset state: fail");
		end
		for (i = 0; i < n_ops; i++) begin
			op = golden[4*i];
			addr = golden[4*i+1];
			data = golden[4*i+2];
			count = golden[4*i+3];
			errors_before = error_count;
			if (op == OP_FETCH) begin
				op_name = "fetch";
				if (data !== (addr ^ DATA_XOR)) begin
					$display("golden line %0d expects data that breaks the memory rule",
						i + 1);
					error_count++;
				end
				fetch_word(addr, data, count);
			end else if (op == OP_FLUSH) begin
				op_name = "flush";
				pulse_flush(count);
			end else begin
				op_name = "unknown";
				$display("golden line %0d holds an unknown operation %h", i + 1, op);
				error_count++;
			end
			if (error_count == errors_before) begin
				pass_tests++;
				$display("test %0d %s %h: pass", i + 1, op_name, addr);
			end else begin
				fail_tests++;
				$display("test %0d %s %h: fail", i + 1, op_name, addr);
			end
		end
		$display("tests passed %0d, failed %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* verif/icache_golden.txt */
// op address data count. op 1 fetch, 2 flush, 0 ends the list.
// data is address ^ c0de0000, count is bus fetches so far.
// Cold misses, indices 0 to 3.
1 00000100 c0de0100 00000001
1 00000104 c0de0104 00000002
1 00000108 c0de0108 00000003
1 0000010c c0de010c 00000004
// Hits, no bus traffic.
1 00000100 c0de0100 00000004
1 00000104 c0de0104 00000004
1 0000010c c0de010c 00000004
1 00000100 c0de0100 00000004
// Conflicts on index 0.
1 00000120 c0de0120 00000005
1 00000100 c0de0100 00000006
1 00000120 c0de0120 00000007
1 00000100 c0de0100 00000008
1 00010100 c0df0100 00000009
1 00000100 c0de0100 0000000a
1 00000104 c0de0104 0000000a
// Flush, then resident lines miss again.
2 00000000 00000000 0000000a
1 00000104 c0de0104 0000000b
1 00000108 c0de0108 0000000c
1 00000104 c0de0104 0000000c
// Mixed sequence under varied ack delays.
1 00000200 c0de0200 0000000d
1 00000214 c0de0214 0000000e
1 00000218 c0de0218 0000000f
1 0000021c c0de021c 00000010
1 00020210 c0dc0210 00000011
1 00000214 c0de0214 00000011
1 00000220 c0de0220 00000012
1 00000200 c0de0200 00000013
1 0000021c c0de021c 00000013
1 00020210 c0dc0210 00000013
2 00000000 00000000 00000013
1 00020210 c0dc0210 00000014
1 00000108 c0de0108 00000015
// End of list.
0 00000000 00000000 00000000

/* sim.f */
rtl/icache_pkg.sv
rtl/icache_bram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the icache testbench with Verilator.
# Exit status is zero only when the log holds the pass line.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module icache_tb -Mdir "$BUILD" -f sim.f \
	|| { echo "verilator build failed"; exit 1; }

# Keep going on a nonzero exit, the log decides.
"./$BUILD/Vicache_tb" > "$LOG" 2>&1 \
	|| echo "simulator exited with a nonzero status"

cat "$LOG"

grep -qx '>>> PASS' "$LOG" \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see $LOG"; exit 1; }
